// ==== cpu16.f ====
src/isaPkg.sv
src/corePkg.sv
src/hostApb.sv
src/fetch.sv
src/decode.sv
src/execute.sv
src/memWriteback.sv
src/cpuTop.sv
testbench/clockGen.sv
testbench/cpuTb.sv

// ==== testbench/cpuTb.sv ====
//########################################
// CPU testbench
// Loads programs over APB, runs them and
// compares the state with an ISA model
//########################################
module cpuTb import isaPkg::*, corePkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int numProgs  = 4;
	localparam int xferAllow = 2 + regCount + 8;  // Run writes, registers, some memory

	logic             clk, rstN;
	logic             psel, penable, pwrite;
	logic [11:0]      paddr;
	logic [wordW-1:0] pwdata, prdata;
	logic             pready, pslverr;

	logic [wordW-1:0] progMem [numProgs][imemDepth];
	int               progLen [numProgs];
	logic [wordW-1:0] expRegs [regCount];
	logic [wordW-1:0] expMem [dmemDepth];
	logic             expValid [dmemDepth];
	logic [wordW-1:0] actRegs [regCount];
	logic [wordW-1:0] actMem [dmemDepth];
	logic             checkReq;
	int               errCount, checkCount, failedTests, cycles, cycleLimit;

	clockGen clkGen (.clk, .rstN);

	cpuTop dut_i (.clk, .rstN, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
		.pready, .pslverr);

	always @(posedge clk) begin
		cycles++;
		if (cycleLimit > 0 && cycles > cycleLimit) begin
			$display("Timeout: the tests did not finish within %0d cycles", cycleLimit);
			$display("Errors found");
			$finish;
		end
	end

	task automatic checkVal(input string name, input logic [wordW-1:0] got,
			input logic [wordW-1:0] exp);
		checkCount++;
		if (got !== exp) begin
			errCount++;
			$display("** Error %s: got 0x%04h, expected 0x%04h", name, got, exp);
		end
	endtask

	// Compares read-back state with the model when asked
	always begin
		wait (checkReq);
		for (int i = 0; i < regCount; i++)
			checkVal($sformatf("r%0d", i), actRegs[i], expRegs[i]);
		for (int a = 0; a < dmemDepth; a++)
			if (expValid[a])
				checkVal($sformatf("dmem[0x%02h]", a), actMem[a], expMem[a]);
		checkReq = 1'b0;
	end

	function automatic logic [15:0] encI1(opcodeT op, logic [2:0] rs, logic [2:0] rd,
			logic [4:0] imm);
		return {op, rs, rd, imm};
	endfunction

	function automatic logic [15:0] encI2(opcodeT op, logic [2:0] rs, logic [7:0] imm);
		return {op, rs, imm};
	endfunction

	function automatic logic [15:0] encJ(logic [10:0] disp);
		return {opJ, disp};
	endfunction

	function automatic logic [15:0] encR(logic [2:0] f, logic [2:0] rs, logic [2:0] rt,
			logic [2:0] rd);
		return {rtypeMajor, f[2], rs, rt, rd, f[1:0]};
	endfunction

	function automatic void emit(int t, logic [15:0] w);
		progMem[t][progLen[t]] = w;
		progLen[t]++;
	endfunction

	function automatic void clearRegs(int t);
		for (int i = 0; i < regCount; i++)
			emit(t, encI2(opLbi, i, 8'd0));
	endfunction

	// ISA model, runs program t from zero state up to HALT
	function automatic void refRun(int t);
		logic [wordW-1:0] r [regCount];
		logic [wordW-1:0] pc, npc, w, rsV, rtV, s5, z5, s8, addr, res;
		logic [4:0]       op;
		logic [2:0]       rd, fn;
		int               steps;
		for (int i = 0; i < regCount; i++)
			r[i] = '0;
		for (int a = 0; a < dmemDepth; a++) begin
			expMem[a]   = '0;
			expValid[a] = 1'b0;
		end
		pc    = '0;
		steps = 0;
		while (steps < 1000) begin
			w    = progMem[t][pc[7:1]];
			op   = w[15:11];
			rd   = w[7:5];
			rsV  = r[w[10:8]];
			rtV  = r[w[7:5]];
			s5   = {{11{w[4]}}, w[4:0]};
			z5   = {11'd0, w[4:0]};
			s8   = {{8{w[7]}}, w[7:0]};
			addr = rsV + s5;
			npc  = pc + 16'd2;
			steps++;
			if (op == opHalt)
				break;
			if (w[15:12] == rtypeMajor) begin
				fn = {w[11], w[1:0]};
				case (fn)
					funcAdd: res = rsV + rtV;
					funcSub: res = rsV - rtV;
					funcAnd: res = rsV & rtV;
					funcOr:  res = rsV | rtV;
					funcXor: res = rsV ^ rtV;
					funcSll: res = rsV << rtV[3:0];
					funcSrl: res = rsV >> rtV[3:0];
					default: res = ($signed(rsV) < $signed(rtV)) ? 16'd1 : 16'd0;
				endcase
				r[w[4:2]] = res;
			end else begin
				case (op)
					opAddi: r[rd] = rsV + s5;
					opSubi: r[rd] = rsV - s5;
					opAndi: r[rd] = rsV & z5;  // Logic ops zero-extend
					opXori: r[rd] = rsV ^ z5;
					opLd:   r[rd] = expMem[addr[7:1]];
					opSt: begin
						expMem[addr[7:1]]   = rtV;
						expValid[addr[7:1]] = 1'b1;
					end
					opLbi:  r[w[10:8]] = s8;
					opBeqz: if (rsV == 0) npc = pc + 16'd2 + s8;
					opBnez: if (rsV != 0) npc = pc + 16'd2 + s8;
					opJ:    npc = pc + 16'd2 + {{5{w[10]}}, w[10:0]};
					opJr:   npc = rsV + s8;
					default: ;
				endcase
			end
			pc = npc;
		end
		if (steps >= 1000) begin
			errCount++;
			$display("Model of program %0d did not reach HALT", t);
		end
		for (int i = 0; i < regCount; i++)
			expRegs[i] = r[i];
	endfunction

	function automatic void buildPrograms();
		clearRegs(0);
		emit(0, encI2(opLbi, 1, 8'h85));
		emit(0, encI2(opLbi, 2, 8'h7f));
		emit(0, encI1(opAddi, 1, 3, 5'h1d));  // -3
		emit(0, encI1(opAddi, 2, 4, 5'h0f));
		emit(0, encI1(opSubi, 2, 5, 5'h10));  // -16
		emit(0, encI1(opAndi, 1, 6, 5'h1f));
		emit(0, encI1(opXori, 1, 7, 5'h10));
		emit(0, encI1(opSubi, 1, 0, 5'h07));
		emit(0, encI2(opHalt, 0, 8'd0));

		clearRegs(1);
		emit(1, encI2(opLbi, 7, 8'd8));
		for (int i = 1; i <= 2; i++) begin
			emit(1, encI2(opLbi, i, $urandom % 256));  // High byte
			emit(1, encR(funcSll, i, 7, i));
			emit(1, encI2(opLbi, 6, $urandom % 256));
			emit(1, encR(funcXor, i, 6, i));
		end
		emit(1, encR(funcAdd, 1, 2, 3));
		emit(1, encR(funcSub, 1, 2, 4));
		emit(1, encR(funcAnd, 1, 2, 5));
		emit(1, encR(funcOr, 1, 2, 6));
		emit(1, encR(funcXor, 1, 2, 7));
		emit(1, encR(funcSlt, 1, 2, 0));
		emit(1, encR(funcSll, 1, 4, 1));
		emit(1, encR(funcSrl, 2, 5, 2));
		emit(1, encI2(opHalt, 0, 8'd0));

		clearRegs(2);
		emit(2, encI2(opLbi, 1, 8'h40));  // Base address
		emit(2, encI2(opLbi, 2, $urandom % 256));
		emit(2, encI2(opLbi, 3, $urandom % 256));
		emit(2, encI2(opLbi, 4, 8'h12));
		emit(2, encI1(opSt, 1, 2, 5'h00));
		emit(2, encI1(opSt, 1, 3, 5'h06));
		emit(2, encI1(opSt, 1, 4, 5'h1e));  // Base minus 2
		emit(2, encI1(opSt, 1, 1, 5'h0e));
		emit(2, encI1(opLd, 1, 5, 5'h00));
		emit(2, encI1(opLd, 1, 6, 5'h06));
		emit(2, encI1(opLd, 1, 7, 5'h1e));
		emit(2, encI1(opLd, 1, 0, 5'h0e));
		emit(2, encI2(opHalt, 0, 8'd0));

		// r7 marks visited paths, r6 paths that must be skipped
		clearRegs(3);
		emit(3, encI2(opBeqz, 0, 8'd2));  // Taken
		emit(3, encI1(opXori, 6, 6, 5'h01));
		emit(3, encI1(opXori, 7, 7, 5'h01));
		emit(3, encI2(opBnez, 0, 8'd2));  // Not taken
		emit(3, encI1(opXori, 7, 7, 5'h02));
		emit(3, encI2(opLbi, 1, 8'd3));
		emit(3, encI2(opBeqz, 1, 8'd2));  // Not taken
		emit(3, encI1(opXori, 7, 7, 5'h04));
		emit(3, encI1(opAddi, 2, 2, 5'h05));  // Loop body
		emit(3, encI1(opSubi, 1, 1, 5'h01));
		emit(3, encI2(opBnez, 1, 8'hfa));
		emit(3, encJ(11'd2));
		emit(3, encI1(opXori, 6, 6, 5'h02));
		emit(3, encI1(opXori, 7, 7, 5'h08));
		emit(3, encI2(opLbi, 3, 8'd28));
		emit(3, encR(funcAdd, 3, 3, 3));
		emit(3, encI2(opJr, 3, 8'hfc));  // 56 - 4 lands on index 26
		emit(3, encI1(opXori, 6, 6, 5'h04));
		emit(3, encI1(opXori, 7, 7, 5'h10));
		emit(3, encI2(opHalt, 0, 8'd0));
	endfunction

	// One transfer, setup then access, entered 1 ns after an edge
	task automatic apbXfer(input logic wr, input logic [11:0] addr,
			input logic [wordW-1:0] data, output logic [wordW-1:0] rdata, output logic err);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = data;
		@(posedge clk);
		#1 penable = 1'b1;
		@(negedge clk);
		rdata = prdata;
		err   = pslverr;
		checkVal("pready", pready, 16'h1);  // No wait states
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apbWrite(input logic [11:0] addr, input logic [wordW-1:0] data,
			output logic err);
		logic [wordW-1:0] unused;
		apbXfer(1'b1, addr, data, unused, err);
	endtask

	task automatic apbRead(input logic [11:0] addr, output logic [wordW-1:0] data);
		logic err;
		apbXfer(1'b0, addr, 16'h0, data, err);
	endtask

	// Toggles run to restart from PC 0, then polls for halt
	task automatic startRun(output logic firstHalted);
		logic [wordW-1:0] d;
		logic err;
		apbWrite(12'h100, 16'h0, err);
		apbWrite(12'h100, 16'h1, err);
		checkVal("pslverr", err, 16'h0);
		apbRead(12'h101, d);
		firstHalted = d[0];
		while (!d[0])
			apbRead(12'h101, d);
	endtask

	task automatic compareState();
		logic [wordW-1:0] d;
		for (int i = 0; i < regCount; i++) begin
			apbRead(12'h200 + i[11:0], d);
			actRegs[i] = d;
		end
		for (int a = 0; a < dmemDepth; a++) begin
			if (expValid[a]) begin
				apbRead(12'h300 + a[11:0], d);
				actMem[a] = d;
			end
		end
		checkReq = 1'b1;
		wait (!checkReq);
	endtask

	task automatic report(input string name, input int errBefore);
		if (errCount == errBefore) begin
			$display("Test %-14s pass", name);
		end else begin
			failedTests++;
			$display("Test %-14s FAIL, %0d mismatches", name, errCount - errBefore);
		end
	endtask

	task automatic runProgram(input int t, input string name);
		logic err;
		logic firstHalted;
		int   errBefore;
		errBefore = errCount;
		for (int i = 0; i < progLen[t]; i++)
			apbWrite(i[11:0], progMem[t][i], err);
		refRun(t);
		startRun(firstHalted);
		checkVal("halted after start", firstHalted, 16'h0);
		compareState();
		report(name, errBefore);
	endtask

	initial begin
		logic [wordW-1:0] d;
		logic err;
		logic firstHalted;
		int   errBefore;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		paddr    = '0;
		pwdata   = '0;
		checkReq = 1'b0;
		void'($urandom(11034));
		buildPrograms();
		cycleLimit = 10;
		for (int t = 0; t < numProgs; t++)
			cycleLimit += (progLen[t] + xferAllow) * 2 + 200;
		cycleLimit += 40 * 2 + 200 + 20;  // Halt and host port test
		wait (rstN === 1'b1);
		@(posedge clk);
		#1;

		runProgram(0, "immediates");
		runProgram(1, "rtype alu");
		runProgram(2, "load store");
		runProgram(3, "control flow");

		// Continues on the halted control flow program
		errBefore = errCount;
		apbRead(12'h101, d);
		checkVal("halted", d, 16'h1);
		repeat (20) @(posedge clk);
		#1;
		apbWrite(12'h101, 16'h0, err);
		checkVal("pslverr", err, 16'h1);
		apbRead(12'h101, d);
		checkVal("halted", d, 16'h1);
		apbRead(12'h100, d);
		checkVal("run", d, 16'h1);  // Status write left run alone
		compareState();
		startRun(firstHalted);
		checkVal("halted after restart", firstHalted, 16'h0);
		compareState();
		report("halt and host", errBefore);

		$display("Tests: 5, failed: %0d, checks: %0d, errors: %0d",
			failedTests, checkCount, errCount);
		if (errCount == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== testbench/clockGen.sv ====
//########################################
// Clock and reset generator
// 10 ns clock, reset low for 4 cycles
//########################################
module clockGen (
	output logic clk,
	output logic rstN
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		rstN = 1'b0;
		repeat (4) @(posedge clk);
		#1 rstN = 1'b1;  // Released with the same skew as stimulus
	end

endmodule

// ==== src/cpuTop.sv ====
//########################################
// CPU top
// Host APB port and the four stages
//########################################
module cpuTop import corePkg::*, isaPkg::*; (
	input  logic             clk,
	input  logic             rstN,
	input  logic             psel,
	input  logic             penable,
	input  logic             pwrite,
	input  logic [11:0]      paddr,
	input  logic [wordW-1:0] pwdata,
	output logic [wordW-1:0] prdata,
	output logic             pready,
	output logic             pslverr
);

	logic                 run;
	logic                 pcClear;
	logic                 halted;
	logic                 imemWe;
	logic [imemAddrW-1:0] imemAddr;
	logic [wordW-1:0]     imemData;
	logic [regAddrW-1:0]  regAddr;
	logic [wordW-1:0]     regData;
	logic [dmemAddrW-1:0] dmemAddr;
	logic [wordW-1:0]     dmemData;
	instrT                instr;
	logic [wordW-1:0]     incPc;
	decodeOutT            decodeOut;
	execOutT              execOut;
	logic [wordW-1:0]     wbData;

	hostApb uHost (
		.clk, .rstN, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
		.pslverr, .halted, .run, .pcClear, .imemWe, .imemAddr, .imemData,
		.regAddr, .regData, .dmemAddr, .dmemData
	);

	fetch uFetch (
		.clk, .rstN, .run, .pcClear,
		.halt   (decodeOut.ctrl.halt),
		.nextPc (execOut.nextPc),
		.imemWe, .imemAddr, .imemData, .instr, .incPc, .halted
	);

	decode uDecode (
		.clk, .rstN, .run, .halted, .instr, .wbData,
		.wbDest     (execOut.dest),
		.wbRegWrite (execOut.regWrite),
		.decodeOut, .regAddr, .regData
	);

	execute uExecute (.instr, .incPc, .decodeOut, .execOut);

	memWriteback uMemWb (.clk, .run, .halted, .execOut, .wbData, .dmemAddr, .dmemData);

endmodule

// ==== src/memWriteback.sv ====
//########################################
// Memory and writeback stage
// Data memory and writeback select
//########################################
module memWriteback import corePkg::*, isaPkg::*; (
	input  logic                 clk,
	input  logic                 run,
	input  logic                 halted,
	input  execOutT              execOut,
	output logic [wordW-1:0]     wbData,
	input  logic [dmemAddrW-1:0] dmemAddr,
	output logic [wordW-1:0]     dmemData
);

	logic [wordW-1:0]     dmem [dmemDepth];
	logic [dmemAddrW-1:0] addr;

	assign addr = execOut.aluResult[dmemAddrW:1];  // Word index of byte address

	always_ff @(posedge clk) begin
		if (run && !halted && execOut.memWrite)
			dmem[addr] <= execOut.writeData;
	end

	// Asynchronous reads for loads and the host
	assign wbData   = execOut.memToReg ? dmem[addr] : execOut.aluResult;
	assign dmemData = dmem[dmemAddr];

endmodule

// ==== src/execute.sv ====
//########################################
// Execute stage
// Immediates, ALU, branch decision and
// next PC
//########################################
module execute import corePkg::*, isaPkg::*; (
	input  instrT            instr,
	input  logic [wordW-1:0] incPc,
	input  decodeOutT        decodeOut,
	output execOutT          execOut
);

	ctrlT             ctrl;
	logic [wordW-1:0] imm1Ext;
	logic [wordW-1:0] imm2Ext;
	logic [wordW-1:0] immVal;
	logic [wordW-1:0] dispExt;
	logic [wordW-1:0] offset;
	logic [wordW-1:0] opA;
	logic [wordW-1:0] opB;
	logic [wordW-1:0] aluResult;
	logic             rsZero;
	logic             taken;

	assign ctrl = decodeOut.ctrl;

	// Immediate extension
	assign imm1Ext = ctrl.signExtend ? {{11{instr.fmtI1.imm[4]}}, instr.fmtI1.imm}
	                                 : {11'd0, instr.fmtI1.imm};
	assign imm2Ext = {{8{instr.fmtI2.imm[7]}}, instr.fmtI2.imm};
	assign dispExt = {{5{instr.fmtJ.disp[10]}}, instr.fmtJ.disp};
	assign immVal  = ctrl.isType1 ? imm1Ext : imm2Ext;
	assign offset  = ctrl.branch ? immVal : dispExt;  // Byte offset from PC+2

	assign opA = decodeOut.readData1;
	assign opB = ctrl.aluSrc ? immVal : decodeOut.readData2;

	always_comb begin
		case (ctrl.aluOp)
			aluAdd:   aluResult = opA + opB;
			aluSub:   aluResult = opA - opB;
			aluAnd:   aluResult = opA & opB;
			aluOr:    aluResult = opA | opB;
			aluXor:   aluResult = opA ^ opB;
			aluSll:   aluResult = opA << opB[3:0];
			aluSrl:   aluResult = opA >> opB[3:0];
			aluSlt:   aluResult = {15'd0, $signed(opA) < $signed(opB)};
			aluPassB: aluResult = opB;
			default:  aluResult = '0;
		endcase
	end

	// Zero test on rs for BEQZ and BNEZ
	assign rsZero = (opA == '0);
	assign taken  = ctrl.branch & (rsZero == ctrl.branchOnZero);

	always_comb begin
		if (ctrl.jr)
			execOut.nextPc = aluResult;
		else if (taken || ctrl.jump)
			execOut.nextPc = incPc + offset;
		else
			execOut.nextPc = incPc;
	end

	assign execOut.aluResult = aluResult;
	assign execOut.writeData = decodeOut.readData2;  // Store data
	assign execOut.dest      = decodeOut.dest;
	assign execOut.regWrite  = ctrl.regWrite;
	assign execOut.memToReg  = ctrl.memToReg;
	assign execOut.memWrite  = ctrl.memWrite;

endmodule

// ==== src/decode.sv ====
//########################################
// Decode stage
// Control unit and the register file
//########################################
module decode import corePkg::*, isaPkg::*; (
	input  logic                clk,
	input  logic                rstN,
	input  logic                run,
	input  logic                halted,
	input  instrT               instr,
	input  logic [wordW-1:0]    wbData,
	input  logic [regAddrW-1:0] wbDest,
	input  logic                wbRegWrite,
	output decodeOutT           decodeOut,
	input  logic [regAddrW-1:0] regAddr,
	output logic [wordW-1:0]    regData
);

	ctrlT                ctrl;
	funcT                func;
	logic [regAddrW-1:0] dest;
	logic [wordW-1:0]    regs [regCount];

	assign func = funcT'({instr.fmtR.funcHi, instr.fmtR.funcLo});

	always_comb begin
		ctrl       = '0;
		ctrl.aluOp = aluAdd;
		dest       = instr.fmtI1.rd;
		if (instr.fmtR.major == rtypeMajor) begin
			ctrl.regWrite = 1'b1;
			ctrl.aluOp    = aluOpT'({1'b0, func});
			dest          = instr.fmtR.rd;
		end else begin
			case (instr.fmtI1.opcode)
				opHalt: ctrl.halt = 1'b1;
				opAddi, opSubi, opAndi, opXori: begin
					ctrl.regWrite   = 1'b1;
					ctrl.aluSrc     = 1'b1;
					ctrl.isType1    = 1'b1;
					// Logic ops take a zero-extended immediate
					ctrl.signExtend = (instr.fmtI1.opcode inside {opAddi, opSubi});
					case (instr.fmtI1.opcode)
						opSubi:  ctrl.aluOp = aluSub;
						opAndi:  ctrl.aluOp = aluAnd;
						opXori:  ctrl.aluOp = aluXor;
						default: ctrl.aluOp = aluAdd;
					endcase
				end
				opLd, opSt: begin
					ctrl.aluSrc     = 1'b1;  // Address is rs plus imm5
					ctrl.isType1    = 1'b1;
					ctrl.signExtend = 1'b1;
					ctrl.regWrite   = (instr.fmtI1.opcode == opLd);
					ctrl.memToReg   = (instr.fmtI1.opcode == opLd);
					ctrl.memWrite   = (instr.fmtI1.opcode == opSt);
				end
				opLbi: begin
					ctrl.regWrite = 1'b1;
					ctrl.aluSrc   = 1'b1;
					ctrl.aluOp    = aluPassB;
					dest          = instr.fmtI2.rs;  // LBI writes its rs field
				end
				opBeqz: begin
					ctrl.branch       = 1'b1;
					ctrl.branchOnZero = 1'b1;
				end
				opBnez: ctrl.branch = 1'b1;
				opJ:    ctrl.jump = 1'b1;
				opJr: begin
					ctrl.jr     = 1'b1;
					ctrl.aluSrc = 1'b1;  // Target is rs plus imm8
				end
				default: ;  // NOP and unused opcodes
			endcase
		end
	end

	// Writeback at the retiring edge
	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < regCount; i++)
				regs[i] <= '0;
		end else if (run && !halted && wbRegWrite) begin
			regs[wbDest] <= wbData;
		end
	end

	assign decodeOut.ctrl      = ctrl;
	assign decodeOut.readData1 = regs[instr.fmtI1.rs];
	assign decodeOut.readData2 = regs[instr.fmtR.rt];  // rt, or rd of a store
	assign decodeOut.dest      = dest;
	assign regData             = regs[regAddr];

endmodule

// ==== src/fetch.sv ====
//########################################
// Fetch stage
// PC register and instruction memory
//########################################
module fetch import corePkg::*, isaPkg::*; (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 run,
	input  logic                 pcClear,
	input  logic                 halt,
	input  logic [wordW-1:0]     nextPc,
	input  logic                 imemWe,
	input  logic [imemAddrW-1:0] imemAddr,
	input  logic [wordW-1:0]     imemData,
	output instrT                instr,
	output logic [wordW-1:0]     incPc,
	output logic                 halted
);

	logic [wordW-1:0] pc;
	logic [wordW-1:0] imem [imemDepth];

	// Byte PC into word memory
	assign instr = imem[pc[imemAddrW:1]];
	assign incPc = pc + 16'd2;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc     <= '0;
			halted <= 1'b0;
		end else if (pcClear) begin
			pc     <= '0;
			halted <= 1'b0;
		end else if (run && !halted) begin
			if (halt)
				halted <= 1'b1;  // PC stays on the HALT
			else
				pc <= nextPc;
		end
	end

	always_ff @(posedge clk) begin
		if (imemWe)
			imem[imemAddr] <= imemData;
	end

endmodule

// ==== src/hostApb.sv ====
//########################################
// Host APB slave
// Program load, run control, status and
// readback of registers and data memory
//########################################
module hostApb import corePkg::*, isaPkg::*; (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 psel,
	input  logic                 penable,
	input  logic                 pwrite,
	input  logic [11:0]          paddr,
	input  logic [wordW-1:0]     pwdata,
	output logic [wordW-1:0]     prdata,
	output logic                 pready,
	output logic                 pslverr,
	input  logic                 halted,
	output logic                 run,
	output logic                 pcClear,
	output logic                 imemWe,
	output logic [imemAddrW-1:0] imemAddr,
	output logic [wordW-1:0]     imemData,
	output logic [regAddrW-1:0]  regAddr,
	input  logic [wordW-1:0]     regData,
	output logic [dmemAddrW-1:0] dmemAddr,
	input  logic [wordW-1:0]     dmemData
);

	logic wrAccess;
	logic ctrlWrite;
	logic inImem;
	logic inCtrl;
	logic inStatus;
	logic inRegs;
	logic inDmem;

	assign wrAccess = psel & penable & pwrite;  // No wait states

	// Word address map
	assign inImem   = (paddr[11:8] == 4'h0) && !paddr[7];
	assign inCtrl   = (paddr == 12'h100);
	assign inStatus = (paddr == 12'h101);
	assign inRegs   = (paddr[11:8] == 4'h2) && (paddr[7:3] == 5'd0);
	assign inDmem   = (paddr[11:8] == 4'h3) && !paddr[7];

	assign imemWe   = wrAccess & inImem;
	assign imemAddr = paddr[imemAddrW-1:0];
	assign imemData = pwdata;
	assign regAddr  = paddr[regAddrW-1:0];
	assign dmemAddr = paddr[dmemAddrW-1:0];

	assign ctrlWrite = wrAccess & inCtrl;
	assign pcClear   = ctrlWrite & pwdata[0] & ~run;  // Run going 0 to 1

	always_ff @(posedge clk) begin
		if (!rstN) begin
			run <= 1'b0;
		end else if (ctrlWrite) begin
			run <= pwdata[0];
		end
	end

	assign pready  = 1'b1;
	assign pslverr = wrAccess & ~(inImem | inCtrl);  // Read-only or unmapped

	always_comb begin
		prdata = '0;
		if (inCtrl)
			prdata = {{(wordW-1){1'b0}}, run};
		else if (inStatus)
			prdata = {{(wordW-1){1'b0}}, halted};
		else if (inRegs)
			prdata = regData;
		else if (inDmem)
			prdata = dmemData;
	end

endmodule

// ==== src/corePkg.sv ====
//########################################
// Core package
// Memory sizes, control bundle and the
// results passed between stages
//########################################
package corePkg;

	import isaPkg::*;

	localparam int regCount  = 8;
	localparam int imemDepth = 128;
	localparam int dmemDepth = 128;
	localparam int regAddrW  = $clog2(regCount);
	localparam int imemAddrW = $clog2(imemDepth);
	localparam int dmemAddrW = $clog2(dmemDepth);

	typedef struct packed {
		logic  halt;
		logic  jump;
		logic  isType1;       // Immediate from I1, else I2
		logic  signExtend;    // Applies to the 5-bit immediate
		logic  jr;
		logic  branch;
		logic  branchOnZero;  // Set for BEQZ
		logic  memToReg;
		logic  memWrite;
		logic  regWrite;
		logic  aluSrc;        // B operand is the immediate
		aluOpT aluOp;
	} ctrlT;

	typedef struct packed {
		ctrlT                ctrl;
		logic [wordW-1:0]    readData1;
		logic [wordW-1:0]    readData2;
		logic [regAddrW-1:0] dest;
	} decodeOutT;

	typedef struct packed {
		logic [wordW-1:0]    aluResult;
		logic [wordW-1:0]    writeData;
		logic [wordW-1:0]    nextPc;
		logic [regAddrW-1:0] dest;
		logic                regWrite;
		logic                memToReg;
		logic                memWrite;
	} execOutT;

endpackage

// ==== src/isaPkg.sv ====
//########################################
// ISA package
// Opcodes, ALU function codes and the four
// instruction word formats of the core
//########################################
package isaPkg;

	localparam int wordW = 16;
	localparam logic [3:0] rtypeMajor = 4'b1101;  // R-type owns opcodes 1101x

	typedef enum logic [4:0] {
		opHalt  = 5'b00000,
		opNop   = 5'b00001,
		opJ     = 5'b00100,
		opJr    = 5'b00101,
		opAddi  = 5'b01000,
		opSubi  = 5'b01001,
		opXori  = 5'b01010,
		opAndi  = 5'b01011,
		opBeqz  = 5'b01100,
		opBnez  = 5'b01101,
		opSt    = 5'b10000,
		opLd    = 5'b10001,
		opLbi   = 5'b11000,
		opRtype = {rtypeMajor, 1'b0}
	} opcodeT;

	typedef enum logic [2:0] {
		funcAdd, funcSub, funcAnd, funcOr, funcXor, funcSll, funcSrl, funcSlt
	} funcT;

	// First eight follow funcT order
	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSll, aluSrl, aluSlt, aluPassB
	} aluOpT;

	typedef struct packed {
		opcodeT     opcode;
		logic [2:0] rs;
		logic [2:0] rd;
		logic [4:0] imm;
	} fmtI1T;

	typedef struct packed {
		opcodeT     opcode;
		logic [2:0] rs;
		logic [7:0] imm;
	} fmtI2T;

	typedef struct packed {
		opcodeT      opcode;
		logic [10:0] disp;
	} fmtJT;

	// Func MSB sits in the opcode LSB, so rs lines up with the I formats
	typedef struct packed {
		logic [3:0] major;
		logic       funcHi;
		logic [2:0] rs;
		logic [2:0] rt;
		logic [2:0] rd;
		logic [1:0] funcLo;
	} fmtRT;

	typedef union packed {
		fmtI1T fmtI1;
		fmtI2T fmtI2;
		fmtJT  fmtJ;
		fmtRT  fmtR;
	} instrT;

endpackage
